/* build.f */
hw/vic_pkg.sv
hw/raster_timing.sv
hw/cycle_sequencer.sv
hw/matrix_fetch.sv
hw/sprite_fetch.sv
hw/bus_arbiter.sv
hw/vic_fetch_top.sv
bench/tb_vic_fetch.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the VIC-II fetch testbench with Verilator

cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -f build.f --top-module tb_vic_fetch -o vic_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/vic_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "Test passed" "$log"; then
    exit 0
fi
exit 1

/* bench/tb_vic_fetch.sv */
`timescale 1ns/1ps

module tb_vic_fetch;
    import vic_pkg::*;

    // One strobed request as seen on the bus
    typedef struct packed {
        access_t     kind;
        logic [13:0] addr;
        logic [8:0]  line;
        logic [6:0]  cyc;
    } rec_t;

    // Lines needed: budget 3x3, refresh 57, sprites 4, badline 54
    localparam int line_clocks = 65 * 2 * dots_per_phase;
    localparam int test_lines = 3 * 3 + 57 + 4 + 54;
    localparam int cycle_limit = (test_lines * line_clocks + 7 * 17) * 11 / 10;

    logic                   clk_dot4x = 1'b0;
    logic                   rst = 1'b1;
    chip_t                  chip = chip_6569r3;
    logic                   den = 1'b0;
    logic [2:0]             yscroll = 3'd0;
    logic [num_sprites-1:0] sprite_dma = '0;
    logic [3:0]             vm_base = 4'd0;
    logic [2:0]             cb_base = 3'd0;
    logic [7:0]             mem_data = 8'h00;
    bus_req_t               bus_req;
    logic [6:0]             cycle_num;
    logic [8:0]             raster_line;

    rec_t   log_q[$];
    int     log_start = 0;
    int     reset_strobes = 0;
    int     cycle_count = 0;
    int     error_count = 0;
    int     check_count = 0;
    integer seed = 32'h1685;

    vic_fetch_top uut (
        .clk_dot4x, .rst, .chip, .den, .yscroll, .sprite_dma, .vm_base,
        .cb_base, .mem_data, .bus_req, .cycle_num, .raster_line
    );

    always #4 clk_dot4x = ~clk_dot4x;

    function automatic logic [7:0] model_data(input logic [13:0] addr);
        return addr[7:0] ^ 8'h5a;
    endfunction

    // Memory answers well before the phase ends
    always @(posedge clk_dot4x) begin
        #1;
        if (bus_req.strobe === 1'b1)
            mem_data = model_data(bus_req.addr);
    end

    always @(negedge clk_dot4x) begin : log_requests
        rec_t rec;
        if (bus_req.strobe === 1'b1) begin
            if (rst)
                reset_strobes++;
            rec.kind = bus_req.kind;
            rec.addr = bus_req.addr;
            rec.line = raster_line;
            rec.cyc = cycle_num;
            log_q.push_back(rec);
        end
    end

    always @(posedge clk_dot4x) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d clock cycles", cycle_limit);
            $display("Test failed");
            $finish;
        end
    end

    task automatic check(input logic ok, input string msg);
        check_count++;
        assert (ok) else begin
            error_count++;
            $display("Error %0t: %s", $time, msg);
        end
    endtask

    task automatic reset_with_config(input chip_t variant, input logic [7:0] dma,
                                     input logic den_val, input logic [2:0] ys,
                                     input logic [3:0] vm, input logic [2:0] cb);
        @(posedge clk_dot4x);
        #1;
        chip = variant;
        sprite_dma = dma;
        den = den_val;
        yscroll = ys;
        vm_base = vm;
        cb_base = cb;
        rst = 1'b1;
        repeat (16) @(posedge clk_dot4x);
        #1;
        rst = 1'b0;
        log_start = log_q.size();
    endtask

    task automatic wait_line(input int target);
        while (raster_line != 9'(target))
            @(negedge clk_dot4x);
    endtask

    function automatic int count_kind(input access_t kind, input int line);
        int n;
        n = 0;
        for (int i = log_start; i < log_q.size(); i++)
            if (log_q[i].kind == kind && int'(log_q[i].line) == line)
                n++;
        return n;
    endfunction

    task automatic reset_quiet();
        reset_with_config(chip_6569r3, 8'h00, 1'b0, 3'd0, 4'h1, 3'd2);
        check(reset_strobes == 0, "strobe was raised while reset was held");
        // Dot 0 and dot 1 of the first phase
        repeat (2) begin
            @(negedge clk_dot4x);
            check(bus_req.strobe == 1'b0, "strobe high before the first phase_start");
        end
    endtask

    task automatic line_budget(input chip_t variant, input int cycles, input int idle);
        int n_ref, n_ptr, n_gfx, n_chr, n_dat, n_idle;
        int last_cyc;
        reset_with_config(variant, 8'h00, 1'b0, 3'd0, 4'h1, 3'd2);
        wait_line(2);
        // Line 0 of the 6567R8 opens mid sprite
        n_ref = count_kind(acc_refresh, 1);
        n_ptr = count_kind(acc_sptr, 1);
        n_gfx = count_kind(acc_gfx, 1);
        n_chr = count_kind(acc_char, 1);
        n_dat = count_kind(acc_sdata, 1);
        n_idle = count_kind(acc_idle, 1);
        check(n_ref == 5 && n_ptr == 8 && n_gfx == 40 && n_chr == 0 && n_dat == 0 &&
              n_idle == idle,
              $sformatf("%s line counts r%0d p%0d g%0d c%0d s%0d i%0d, expected idle %0d",
                        variant.name(), n_ref, n_ptr, n_gfx, n_chr, n_dat, n_idle, idle));
        // Every low phase strobes, so the last access sits in the last cycle
        last_cyc = 0;
        for (int i = log_start; i < log_q.size(); i++)
            if (int'(log_q[i].line) == 1 && int'(log_q[i].cyc) > last_cyc)
                last_cyc = int'(log_q[i].cyc);
        check(last_cyc == cycles - 1,
              $sformatf("%s line 1 ends at cycle %0d, expected %0d", variant.name(),
                        last_cyc, cycles - 1));
    endtask

    task automatic refresh_sequence();
        int n;
        logic [7:0] low;
        reset_with_config(chip_6569r3, 8'h00, 1'b0, 3'd0, 4'h1, 3'd2);
        wait_line(56);
        n = 0;
        for (int i = log_start; i < log_q.size(); i++) begin
            if (log_q[i].kind == acc_refresh) begin
                low = 8'hff - 8'(n);
                check(log_q[i].addr == {6'h3f, low},
                      $sformatf("refresh %0d at %h, expected %h", n, log_q[i].addr,
                                {6'h3f, low}));
                n++;
            end
        end
        check(n == 280, $sformatf("%0d refresh accesses in 56 lines, expected 280", n));
    endtask

    task automatic sprite_dma_fetch();
        logic [7:0]  mask;
        logic [7:0]  ptr;
        logic [13:0] exp_addr;
        int          ptr_idx[$];
        int          mc[num_sprites];
        int          spr;
        int          found;
        mask = 8'($random(seed));
        reset_with_config(chip_6569r3, mask, 1'b0, 3'd0, 4'h3, 3'd0);
        wait_line(3);
        for (int i = log_start; i < log_q.size(); i++)
            if (log_q[i].kind == acc_sptr)
                ptr_idx.push_back(i);
        foreach (mc[s])
            mc[s] = 0;
        check(ptr_idx.size() > 16, "too few sprite pointer fetches were logged");
        spr = 3;
        // Two full passes over all sprites
        for (int p = 0; p < 16 && ptr_idx.size() > 16; p++) begin
            exp_addr = 14'(3 * 1024 + 'h3f8 + spr);
            check(log_q[ptr_idx[p]].addr == exp_addr,
                  $sformatf("sprite %0d pointer at %h, expected %h", spr,
                            log_q[ptr_idx[p]].addr, exp_addr));
            ptr = model_data(exp_addr);
            found = 0;
            for (int k = ptr_idx[p] + 1; k < ptr_idx[p + 1]; k++) begin
                if (log_q[k].kind == acc_sdata) begin
                    exp_addr = 14'(int'(ptr) * 64 + mc[spr] + found);
                    check(k == ptr_idx[p] + 1 + found && log_q[k].addr == exp_addr,
                          $sformatf("sprite %0d data at %h, expected %h right after pointer",
                                    spr, log_q[k].addr, exp_addr));
                    found++;
                end
            end
            check(found == (mask[spr] ? 3 : 0),
                  $sformatf("sprite %0d got %0d data accesses, mask %h", spr, found, mask));
            mc[spr] = mask[spr] ? mc[spr] + 3 : 0;
            spr = (spr + 1) % num_sprites;
        end
    endtask

    task automatic badline_fetch();
        rec_t        rec;
        logic [7:0]  code;
        logic [13:0] exp_addr;
        int          vm;
        int          cb;
        int          chars;
        int          rc;
        int          g_cnt[2];
        vm = 1;
        cb = 2;
        chars = 0;
        g_cnt[0] = 0;
        g_cnt[1] = 0;
        reset_with_config(chip_6567r56a, 8'h00, 1'b1, 3'd3, 4'(vm), 3'(cb));
        wait_line(53);
        // Line 51 is the first badline with yscroll 3
        for (int ln = 0; ln < 53; ln++)
            if (ln != 51)
                check(count_kind(acc_char, ln) == 0,
                      $sformatf("c-access on line %0d, which is no badline", ln));
        for (int i = log_start; i < log_q.size(); i++) begin
            rec = log_q[i];
            if (rec.kind == acc_char && rec.line == 9'd51) begin
                exp_addr = 14'(vm * 1024 + chars);
                check(rec.addr == exp_addr,
                      $sformatf("c-access %0d at %h, expected %h", chars, rec.addr, exp_addr));
                chars++;
            end
            if (rec.kind == acc_gfx && rec.line >= 9'd51 && rec.line <= 9'd52) begin
                rc = int'(rec.line) - 51;
                code = model_data(14'(vm * 1024 + g_cnt[rc]));
                exp_addr = 14'(cb * 2048 + int'(code) * 8 + rc);
                check(rec.addr == exp_addr,
                      $sformatf("g-access %0d with rc %0d at %h, expected %h", g_cnt[rc], rc,
                                rec.addr, exp_addr));
                g_cnt[rc]++;
            end
        end
        check(chars == 40, $sformatf("%0d c-accesses on the badline, expected 40", chars));
        check(g_cnt[0] == 40 && g_cnt[1] == 40,
              $sformatf("g-access counts %0d and %0d, expected 40", g_cnt[0], g_cnt[1]));
    endtask

    initial begin
        reset_quiet();
        line_budget(chip_6569r3, 63, 10);
        line_budget(chip_6567r56a, 64, 11);
        line_budget(chip_6567r8, 65, 12);
        refresh_sequence();
        sprite_dma_fetch();
        badline_fetch();
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

/* hw/vic_fetch_top.sv */
`timescale 1ns/1ps

module vic_fetch_top (
    input  logic                            clk_dot4x,
    input  logic                            rst,
    input  vic_pkg::chip_t                  chip,
    input  logic                            den,
    input  logic [2:0]                      yscroll,
    input  logic [vic_pkg::num_sprites-1:0] sprite_dma,
    input  logic [3:0]                      vm_base,
    input  logic [2:0]                      cb_base,
    input  logic [7:0]                      mem_data,
    output vic_pkg::bus_req_t               bus_req,
    output logic [6:0]                      cycle_num,
    output logic [8:0]                      raster_line
);
    import vic_pkg::*;

    logic        clk_phi;
    logic        phase_start;
    logic        phase_last;
    logic        badline;
    cycle_t      cycle_type;
    logic [2:0]  sprite_cnt;
    logic [13:0] matrix_addr;
    logic [13:0] sprite_addr;
    logic        matrix_grant;
    logic        sprite_grant;

    raster_timing u_timing (
        .clk_dot4x, .rst, .chip, .den, .yscroll, .clk_phi, .phase_start,
        .phase_last, .cycle_num, .raster_line, .badline
    );

    cycle_sequencer u_seq (
        .clk_dot4x, .rst, .chip, .clk_phi, .phase_start, .sprite_dma,
        .badline, .cycle_num, .cycle_type, .sprite_cnt
    );

    matrix_fetch u_matrix (
        .clk_dot4x, .rst, .phase_last, .grant(matrix_grant), .cycle_type,
        .badline, .cycle_num, .vm_base, .cb_base, .mem_data, .addr(matrix_addr)
    );

    sprite_fetch u_sprite (
        .clk_dot4x, .rst, .phase_last, .grant(sprite_grant), .cycle_type,
        .sprite_cnt, .sprite_dma, .vm_base, .mem_data, .addr(sprite_addr)
    );

    bus_arbiter u_arb (
        .clk_dot4x, .rst, .phase_start, .cycle_type, .matrix_addr, .sprite_addr,
        .matrix_grant, .sprite_grant, .bus_req
    );

endmodule

/* hw/bus_arbiter.sv */
`timescale 1ns/1ps

module bus_arbiter (
    input  logic              clk_dot4x,
    input  logic              rst,
    input  logic              phase_start,
    input  vic_pkg::cycle_t   cycle_type,
    input  logic [13:0]       matrix_addr,
    input  logic [13:0]       sprite_addr,
    output logic              matrix_grant,
    output logic              sprite_grant,
    output vic_pkg::bus_req_t bus_req
);
    import vic_pkg::*;

    access_t     kind;
    logic [13:0] addr;
    logic [7:0]  refresh_cnt;
    logic        start_d;

    always_comb begin
        case (cycle_type)
            vic_lp:                    kind = acc_sptr;
            vic_hs1, vic_ls2, vic_hs3: kind = acc_sdata;
            vic_lr:                    kind = acc_refresh;
            vic_hrc, vic_hgc:          kind = acc_char;
            vic_lg:                    kind = acc_gfx;
            vic_lpi2, vic_li:          kind = acc_idle;
            default:                   kind = acc_none;
        endcase
    end

    always_comb begin
        case (kind)
            acc_sptr, acc_sdata: addr = sprite_addr;
            acc_char, acc_gfx:   addr = matrix_addr;
            acc_refresh:         addr = refresh_base | {6'd0, refresh_cnt};
            default:             addr = idle_addr;
        endcase
    end

    assign sprite_grant = kind == acc_sptr || kind == acc_sdata;
    assign matrix_grant = kind == acc_char || kind == acc_gfx;

    // Cycle type settles one clock after phase_start
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            start_d <= 1'b0;
            bus_req <= '0;
            refresh_cnt <= 8'hff;
        end else begin
            start_d <= phase_start;
            bus_req.strobe <= 1'b0;
            if (start_d) begin
                bus_req.strobe <= kind != acc_none;
                bus_req.kind <= kind;
                bus_req.addr <= addr;
                if (kind == acc_refresh)
                    refresh_cnt <= refresh_cnt - 8'd1;
            end
        end
    end

endmodule

/* hw/sprite_fetch.sv */
`timescale 1ns/1ps

module sprite_fetch (
    input  logic                            clk_dot4x,
    input  logic                            rst,
    input  logic                            phase_last,
    input  logic                            grant,
    input  vic_pkg::cycle_t                 cycle_type,
    input  logic [2:0]                      sprite_cnt,
    input  logic [vic_pkg::num_sprites-1:0] sprite_dma,
    input  logic [3:0]                      vm_base,
    input  logic [7:0]                      mem_data,
    output logic [13:0]                     addr
);
    import vic_pkg::*;

    logic [7:0] ptr;
    logic [5:0] mc [num_sprites];
    logic       ptr_access;
    logic       data_access;

    assign ptr_access = grant && cycle_type == vic_lp;
    assign data_access = grant && (cycle_type == vic_hs1 || cycle_type == vic_ls2 ||
                                   cycle_type == vic_hs3);

    // Pointers sit at the end of the video matrix
    assign addr = (cycle_type == vic_lp) ? {vm_base, ptr_offset + {7'd0, sprite_cnt}}
                                         : {ptr, mc[sprite_cnt]};

    always_ff @(posedge clk_dot4x) begin
        if (phase_last && ptr_access)
            ptr <= mem_data;
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            for (int i = 0; i < num_sprites; i++)
                mc[i] <= '0;
        end else if (phase_last) begin
            if (ptr_access && !sprite_dma[sprite_cnt])
                mc[sprite_cnt] <= '0;
            if (data_access)
                mc[sprite_cnt] <= mc[sprite_cnt] + 6'd1;
        end
    end

endmodule

/* hw/matrix_fetch.sv */
`timescale 1ns/1ps

module matrix_fetch (
    input  logic            clk_dot4x,
    input  logic            rst,
    input  logic            phase_last,
    input  logic            grant,
    input  vic_pkg::cycle_t cycle_type,
    input  logic            badline,
    input  logic [6:0]      cycle_num,
    input  logic [3:0]      vm_base,
    input  logic [2:0]      cb_base,
    input  logic [7:0]      mem_data,
    output logic [13:0]     addr
);
    import vic_pkg::*;

    logic [9:0] vc;
    logic [9:0] vcbase;
    logic [2:0] rc;
    logic [5:0] vmli;
    logic       display;
    logic [7:0] line_buf [0:39];
    logic       c_access;
    logic       g_access;

    assign c_access = grant && (cycle_type == vic_hrc || cycle_type == vic_hgc);
    assign g_access = grant && cycle_type == vic_lg;

    assign addr = (cycle_type == vic_lg) ? {cb_base, line_buf[vmli], rc} : {vm_base, vc};

    // Character codes for the current row
    always_ff @(posedge clk_dot4x) begin
        if (phase_last && c_access)
            line_buf[vmli] <= mem_data;
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            vc <= '0;
            vcbase <= '0;
            rc <= '0;
            vmli <= '0;
            display <= 1'b0;
        end else if (phase_last) begin
            if (g_access) begin
                vc <= vc + 10'd1;
                vmli <= vmli + 6'd1;
            end
            // Last refresh slot of cycle 14
            if (cycle_num == 7'd14 && cycle_type == vic_lr) begin
                vc <= vcbase;
                vmli <= '0;
                if (badline) begin
                    rc <= '0;
                    display <= 1'b1;
                end
            end
            // Low phase of cycle 58 lies in the sprite slots on every chip
            if (cycle_num == 7'd58 && display &&
                (cycle_type == vic_lp || cycle_type == vic_lpi2 || cycle_type == vic_ls2)) begin
                rc <= rc + 3'd1;
                if (rc == 3'd7) begin
                    vcbase <= vc;
                    display <= 1'b0;
                end
            end
        end
    end

endmodule

/* hw/cycle_sequencer.sv */
`timescale 1ns/1ps

module cycle_sequencer (
    input  logic                          clk_dot4x,
    input  logic                          rst,
    input  vic_pkg::chip_t                chip,
    input  logic                          clk_phi,
    input  logic                          phase_start,
    input  logic [vic_pkg::num_sprites-1:0] sprite_dma,
    input  logic                          badline,
    input  logic [6:0]                    cycle_num,
    output vic_pkg::cycle_t               cycle_type,
    output logic [2:0]                    sprite_cnt
);
    import vic_pkg::*;

    // Stretch counters for the refresh and idle runs
    logic [2:0] refresh_cnt;
    logic [2:0] idle_cnt;

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            if (chip == chip_6567r8) begin
                cycle_type <= vic_ls2;
                idle_cnt <= 3'd4;
            end else begin
                cycle_type <= vic_lp;
                idle_cnt <= 3'd3;
            end
            sprite_cnt <= 3'd3;
            refresh_cnt <= '0;
        end else if (phase_start) begin
            if (clk_phi) begin
                // Entering a high phase
                case (cycle_type)
                    vic_lp:   cycle_type <= sprite_dma[sprite_cnt] ? vic_hs1 : vic_hpi1;
                    vic_lpi2: cycle_type <= vic_hpi3;
                    vic_ls2:  cycle_type <= vic_hs3;
                    vic_lr: begin
                        if (refresh_cnt == 3'd4)
                            cycle_type <= badline ? vic_hrc : vic_hrx;
                        else
                            cycle_type <= vic_hri;
                    end
                    vic_lg: begin
                        if (cycle_num == 7'd54) begin
                            cycle_type <= vic_hi;
                            idle_cnt <= '0;
                        end else begin
                            cycle_type <= badline ? vic_hgc : vic_hgi;
                        end
                    end
                    vic_li:   cycle_type <= vic_hi;
                    default: ;
                endcase
            end else begin
                // Entering a low phase
                case (cycle_type)
                    vic_hs1:  cycle_type <= vic_ls2;
                    vic_hpi1: cycle_type <= vic_lpi2;
                    vic_hs3, vic_hpi3: begin
                        if (sprite_cnt == 3'd7) begin
                            // 6567R8 inserts its extra idle slot here
                            cycle_type <= (chip == chip_6567r8) ? vic_li : vic_lr;
                            sprite_cnt <= '0;
                            refresh_cnt <= '0;
                        end else begin
                            cycle_type <= vic_lp;
                            sprite_cnt <= sprite_cnt + 3'd1;
                        end
                    end
                    vic_hri: begin
                        cycle_type <= vic_lr;
                        refresh_cnt <= refresh_cnt + 3'd1;
                    end
                    vic_hrc, vic_hrx, vic_hgc, vic_hgi: cycle_type <= vic_lg;
                    vic_hi: begin
                        if (chip == chip_6567r56a && idle_cnt == 3'd3) begin
                            cycle_type <= vic_lp;
                        end else if (chip == chip_6567r8 && idle_cnt == 3'd3) begin
                            // Count ahead so the slot after sprite 7 leads to refresh
                            idle_cnt <= idle_cnt + 3'd1;
                            cycle_type <= vic_lp;
                        end else if (chip == chip_6567r8 && idle_cnt == 3'd4) begin
                            cycle_type <= vic_lr;
                        end else if (chip[0] && idle_cnt == 3'd2) begin
                            cycle_type <= vic_lp;
                        end else begin
                            idle_cnt <= idle_cnt + 3'd1;
                            cycle_type <= vic_li;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

/* hw/raster_timing.sv */
`timescale 1ns/1ps

module raster_timing (
    input  logic           clk_dot4x,
    input  logic           rst,
    input  vic_pkg::chip_t chip,
    input  logic           den,
    input  logic [2:0]     yscroll,
    output logic           clk_phi,
    output logic           phase_start,
    output logic           phase_last,
    output logic [6:0]     cycle_num,
    output logic [8:0]     raster_line,
    output logic           badline
);
    import vic_pkg::*;

    logic [3:0] dot_cnt;
    logic [6:0] last_cycle;
    logic [8:0] last_line;

    always_comb begin
        case (chip)
            chip_6567r8:   last_cycle = 7'(cycles_6567r8 - 1);
            chip_6567r56a: last_cycle = 7'(cycles_6567r56a - 1);
            default:       last_cycle = 7'(cycles_6569 - 1);
        endcase
    end

    assign last_line = chip[0] ? 9'(lines_pal - 1) : 9'(lines_ntsc - 1);

    // Second and last dot4x clock of each phase
    assign phase_start = dot_cnt == 4'd1;
    assign phase_last = dot_cnt == 4'(dots_per_phase - 1);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            dot_cnt <= '0;
            clk_phi <= 1'b0;
            cycle_num <= '0;
            raster_line <= '0;
        end else begin
            dot_cnt <= dot_cnt + 4'd1;
            if (phase_last) begin
                dot_cnt <= '0;
                clk_phi <= ~clk_phi;
                // End of a high phase closes the bus cycle
                if (clk_phi) begin
                    if (cycle_num == last_cycle) begin
                        cycle_num <= '0;
                        raster_line <= (raster_line == last_line) ? 9'd0 : raster_line + 9'd1;
                    end else begin
                        cycle_num <= cycle_num + 7'd1;
                    end
                end
            end
        end
    end

    assign badline = den && raster_line >= 9'(badline_first) &&
                     raster_line <= 9'(badline_last) && raster_line[2:0] == yscroll;

endmodule

/* hw/vic_pkg.sv */
package vic_pkg;

    // Sprite count and dot4x clocks per phi phase
    localparam int num_sprites = 8;
    localparam int dots_per_phase = 16;

    // Raster geometry per chip family
    localparam int cycles_6567r8 = 65;
    localparam int cycles_6567r56a = 64;
    localparam int cycles_6569 = 63;
    localparam int lines_ntsc = 263;
    localparam int lines_pal = 312;
    localparam int badline_first = 48;
    localparam int badline_last = 247;

    // Fixed addresses on the video bus
    localparam logic [13:0] refresh_base = 14'h3f00;
    localparam logic [13:0] idle_addr = 14'h3fff;
    localparam logic [9:0] ptr_offset = 10'h3f8;

    // Bit 0 set marks a 6569 part
    typedef enum logic [1:0] {
        chip_6567r8   = 2'd0,
        chip_6569r3   = 2'd1,
        chip_6567r56a = 2'd2,
        chip_6569r1   = 2'd3
    } chip_t;

    // Low phase types first, then high phase types
    typedef enum logic [3:0] {
        vic_lp, vic_lpi2, vic_ls2, vic_lr, vic_lg, vic_li,
        vic_hs1, vic_hs3, vic_hpi1, vic_hpi3, vic_hri,
        vic_hrc, vic_hrx, vic_hgc, vic_hgi, vic_hi
    } cycle_t;

    typedef enum logic [2:0] {
        acc_none, acc_idle, acc_refresh, acc_char, acc_gfx, acc_sptr, acc_sdata
    } access_t;

    // One request on the video memory bus
    typedef struct packed {
        logic        strobe;
        access_t     kind;
        logic [13:0] addr;
    } bus_req_t;

endpackage
